// File: logic/microPkg.sv
// Shared types and microinstruction field definitions for the microcoded core.
// Modules import this package in their headers. The testbench also uses these
// localparams to assemble microinstructions.

`default_nettype none

package microPkg;

    localparam int WordW = 16;
    localparam int IoW = 8;
    localparam int AluW = 6;
    localparam int SelW = 3;

    typedef logic [WordW-1:0] wordT;      // Registers, bus and program counter.
    typedef logic [WordW-1:0] uinstrT;
    typedef logic [IoW-1:0]   ioByteT;
    typedef logic [SelW-1:0]  srcSelT;
    typedef logic [SelW-1:0]  dstSelT;
    typedef logic [AluW-1:0]  aluCtrlT;   // EX, NX, EY, NY, F, NO from msb down.

    // Field positions inside the microinstruction.
    localparam int BitEo = 15;
    localparam int BitAluHi = 14;
    localparam int BitAluLo = 9;
    localparam int BitSrcHi = 14;
    localparam int BitSrcLo = 12;
    localparam int BitRt = 11;            // Only when EO is clear.
    localparam int BitPp = 10;            // Only when EO is clear.
    localparam int BitDstHi = 7;
    localparam int BitDstLo = 5;
    localparam int BitJz = 4;
    localparam int BitJgt = 3;
    localparam int BitJlt = 2;
    localparam int BitJc = 1;

    // Bus sources, used when EO is clear.
    localparam srcSelT SrcPc = 3'b000;
    localparam srcSelT SrcIoh = 3'b001;
    localparam srcSelT SrcIol = 3'b010;
    localparam srcSelT SrcMem = 3'b011;
    localparam srcSelT SrcD = 3'b110;

    // Destinations, one at a time.
    localparam dstSelT DstNone = 3'b000;
    localparam dstSelT DstA = 3'b001;
    localparam dstSelT DstI = 3'b010;
    localparam dstSelT DstMem = 3'b011;
    localparam dstSelT DstX = 3'b100;
    localparam dstSelT DstY = 3'b101;
    localparam dstSelT DstD = 3'b110;

endpackage

`default_nettype wire

// File: logic/ctrlIf.sv
// Decoded control lines between the decode stage and the execute and
// writeback stages. Decode drives everything; execute only needs the
// bus-forming fields, writeback the destination, PC and jump fields.

`default_nettype none

interface ctrlIf import microPkg::*; ();

    logic    valid;     // One decoded instruction this cycle.
    logic    eo;
    aluCtrlT aluCtrl;
    srcSelT  srcSel;
    dstSelT  dstSel;
    logic    rt;
    logic    pp;
    logic    jz;
    logic    jgt;
    logic    jlt;
    logic    jc;

    modport dec (
        output valid, eo, aluCtrl, srcSel, dstSel,
        output rt, pp, jz, jgt, jlt, jc
    );

    modport exe (
        input eo, aluCtrl, srcSel
    );

    // Writeback gates everything with valid.
    modport wb (
        input valid, dstSel, rt, pp,
        input jz, jgt, jlt, jc
    );

endinterface

`default_nettype wire

// File: logic/microDecode.sv
// Microinstruction decode.
// Captures the microinstruction on each uValid strobe, then registers its
// split fields onto the control interface one cycle later. Valid follows the
// strobe, so cycles without a strobe leave the later stages idle.

`default_nettype none

module microDecode import microPkg::*; (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire uinstrT uinstr,
    input  wire logic   uValid,
    ctrlIf.dec          ctrl
);

    uinstrT  uinstrQ;
    logic    validQ;
    logic    eoD;
    aluCtrlT aluCtrlD;
    srcSelT  srcSelD;
    logic    rtD;
    logic    ppD;

    // Input capture.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= uValid;
        end
    end

    always_ff @(posedge clk) begin
        if (uValid) begin
            uinstrQ <= uinstr;
        end
    end

    // Bits 14..9 mean ALU controls or source/RT/PP depending on EO.
    always_comb begin
        eoD = uinstrQ[BitEo];
        aluCtrlD = '0;
        srcSelD = '0;
        rtD = 1'b0;
        ppD = 1'b0;
        if (eoD) begin
            aluCtrlD = uinstrQ[BitAluHi:BitAluLo];
        end else begin
            srcSelD = uinstrQ[BitSrcHi:BitSrcLo];
            rtD = uinstrQ[BitRt];
            ppD = uinstrQ[BitPp];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl.valid <= 1'b0;
            ctrl.eo <= 1'b0;
            ctrl.aluCtrl <= '0;
            ctrl.srcSel <= '0;
            ctrl.dstSel <= '0;
            ctrl.rt <= 1'b0;
            ctrl.pp <= 1'b0;
            ctrl.jz <= 1'b0;
            ctrl.jgt <= 1'b0;
            ctrl.jlt <= 1'b0;
            ctrl.jc <= 1'b0;
        end else begin
            ctrl.valid <= validQ;
            if (validQ) begin                           // Fields hold between strobes.
                ctrl.eo <= eoD;
                ctrl.aluCtrl <= aluCtrlD;
                ctrl.srcSel <= srcSelD;
                ctrl.dstSel <= uinstrQ[BitDstHi:BitDstLo];
                ctrl.rt <= rtD;
                ctrl.pp <= ppD;
                ctrl.jz <= uinstrQ[BitJz];
                ctrl.jgt <= uinstrQ[BitJgt];
                ctrl.jlt <= uinstrQ[BitJlt];
                ctrl.jc <= uinstrQ[BitJc];
            end
        end
    end

    // The strobe must be driven once reset is released.
    uValidKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(uValid));

endmodule

`default_nettype wire

// File: logic/aluExecute.sv
// Execute stage.
// Purely combinational. Forms the internal bus value either from the ALU or
// from the selected source, and derives the zero, negative and carry flags
// that writeback uses for conditional jumps.

`default_nettype none

module aluExecute import microPkg::*; (
    ctrlIf.exe          ctrl,
    input  wire wordT   xValue,
    input  wire wordT   yValue,
    input  wire wordT   dValue,
    input  wire wordT   pcValue,
    input  wire ioByteT ioIn,
    input  wire wordT   memRdata,
    output wordT        busValue,
    output logic        zero,
    output logic        neg,
    output logic        carry
);

    logic             ex;
    logic             nx;
    logic             ey;
    logic             ny;
    logic             fn;
    logic             no;
    wordT             xOp;
    wordT             yOp;
    logic [WordW:0]   sumFull;
    wordT             aluResult;
    logic             aluCarry;
    wordT             srcValue;

    assign {ex, nx, ey, ny, fn, no} = ctrl.aluCtrl;

    always_comb begin
        xOp = ex ? xValue : '0;                        // Masked operand.
        if (nx) begin
            xOp = ~xOp;
        end
        yOp = ey ? yValue : '0;
        if (ny) begin
            yOp = ~yOp;
        end
        sumFull = {1'b0, xOp} + {1'b0, yOp};
        if (fn) begin
            aluResult = sumFull[WordW-1:0];
            aluCarry = sumFull[WordW];
        end else begin
            aluResult = xOp & yOp;
            aluCarry = 1'b0;
        end
        if (no) begin
            aluResult = ~aluResult;                    // Carry is not inverted.
        end
    end

    // Source multiplexer when EO is clear.
    always_comb begin
        case (ctrl.srcSel)
            SrcPc:   srcValue = pcValue;
            SrcIoh:  srcValue = {ioIn, {IoW{1'b0}}};
            SrcIol:  srcValue = {{(WordW-IoW){1'b0}}, ioIn};
            SrcMem:  srcValue = memRdata;
            SrcD:    srcValue = dValue;
            default: srcValue = '0;
        endcase
    end

    assign busValue = ctrl.eo ? aluResult : srcValue;
    assign zero = (busValue == '0);
    assign neg = busValue[WordW-1];                    // Sign bit.
    assign carry = ctrl.eo & aluCarry;

endmodule

`default_nettype wire

// File: logic/regWriteback.sv
// Writeback stage.
// Holds the A, I, X, Y and D registers and the program counter. A valid
// instruction loads its destination from the bus, may write memory at the
// address in A, and steps the program counter. Memory write is a plain
// strobe sampled by the memory at the next clock edge.

`default_nettype none

module regWriteback import microPkg::*; (
    input  wire logic clk,
    input  wire logic rstN,
    ctrlIf.wb         ctrl,
    input  wire wordT busValue,
    input  wire logic zero,
    input  wire logic neg,
    input  wire logic carry,
    output wordT      memAddr,
    output wordT      memWdata,
    output logic      memWe,
    output wordT      aValue,
    output wordT      iValue,
    output wordT      xValue,
    output wordT      yValue,
    output wordT      dValue,
    output wordT      pcValue
);

    wordT aReg;
    wordT iReg;
    wordT xReg;
    wordT yReg;
    wordT dReg;
    wordT pcReg;
    wordT pcNext;
    logic jumpTaken;

    assign jumpTaken = (ctrl.jz & zero)
                     | (ctrl.jgt & ~zero & ~neg)
                     | (ctrl.jlt & neg)
                     | (ctrl.jc & carry);

    // RT wins over a taken jump, a jump wins over PP.
    always_comb begin
        pcNext = pcReg;
        if (ctrl.rt) begin
            pcNext = dReg;
        end else if (jumpTaken) begin
            pcNext = aReg;
        end else if (ctrl.pp) begin
            pcNext = pcReg + wordT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aReg <= '0;
            iReg <= '0;
            xReg <= '0;
            yReg <= '0;
            dReg <= '0;
            pcReg <= '0;
        end else if (ctrl.valid) begin
            case (ctrl.dstSel)
                DstA:            aReg <= busValue;
                DstI:            iReg <= busValue;
                DstX:            xReg <= busValue;
                DstY:            yReg <= busValue;
                DstD:            dReg <= busValue;
                DstNone, DstMem: ;                    // No register load.
                default:         ;
            endcase
            pcReg <= pcNext;
        end
    end

    assign memAddr = aReg;
    assign memWdata = busValue;
    assign memWe = ctrl.valid && (ctrl.dstSel == DstMem);

    assign aValue = aReg;
    assign iValue = iReg;
    assign xValue = xReg;
    assign yValue = yReg;
    assign dValue = dReg;
    assign pcValue = pcReg;

    // A memory write carries a known address and data.
    memWriteKnown: assert property (@(posedge clk) disable iff (!rstN)
        memWe |-> !$isunknown({memAddr, memWdata}));

    pcKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(pcReg));

endmodule

`default_nettype wire

// File: logic/microCore.sv
// Top level of the microcoded datapath core.
// Takes one microinstruction per uValid strobe; its effect on the registers
// and the program counter shows two cycles after the strobe is sampled.
// Memory is external: reads are combinational on memAddr, writes on memWe.

`default_nettype none

module microCore import microPkg::*; (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire uinstrT uinstr,
    input  wire logic   uValid,
    input  wire ioByteT ioIn,
    input  wire wordT   memRdata,
    output wordT        memAddr,
    output wordT        memWdata,
    output logic        memWe,
    output wordT        pc,
    output wordT        regI,
    output wordT        regX,
    output wordT        regY,
    output wordT        regD
);

    wordT busValue;
    logic zero;
    logic neg;
    logic carry;

    ctrlIf ctrl ();

    microDecode uDecode (
        .clk    (clk),
        .rstN   (rstN),
        .uinstr (uinstr),
        .uValid (uValid),
        .ctrl   (ctrl.dec)
    );

    aluExecute uExecute (
        .ctrl     (ctrl.exe),
        .xValue   (regX),
        .yValue   (regY),
        .dValue   (regD),
        .pcValue  (pc),
        .ioIn     (ioIn),
        .memRdata (memRdata),
        .busValue (busValue),
        .zero     (zero),
        .neg      (neg),
        .carry    (carry)
    );

    // A leaves the core only as the memory address.
    regWriteback uWriteback (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl.wb),
        .busValue (busValue),
        .zero     (zero),
        .neg      (neg),
        .carry    (carry),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .aValue   (),
        .iValue   (regI),
        .xValue   (regX),
        .yValue   (regY),
        .dValue   (regD),
        .pcValue  (pc)
    );

endmodule

`default_nettype wire

// File: test/refModel.svh
// Reference model of one microinstruction on the architectural state.
// Included inside the testbench module after the package import. The caller
// passes in the memory word at A and applies any returned memory write.

`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef struct packed {
    wordT a;
    wordT i;
    wordT x;
    wordT y;
    wordT d;
    wordT pc;
} archStateT;

typedef struct packed {
    archStateT next;
    logic      memWe;
    wordT      memWdata;
} stepResultT;

function automatic stepResultT stepModel(archStateT s, uinstrT u, ioByteT io, wordT memWord);
    stepResultT     r;
    aluCtrlT        ctl;
    wordT           xOp;
    wordT           yOp;
    logic [WordW:0] sum;
    wordT           bus;
    logic           cy;
    logic           jump;
    ctl = u[BitAluHi:BitAluLo];
    xOp = ctl[5] ? s.x : '0;                    // EX masks, NX inverts.
    xOp = ctl[4] ? ~xOp : xOp;
    yOp = ctl[3] ? s.y : '0;
    yOp = ctl[2] ? ~yOp : yOp;
    sum = {1'b0, xOp} + {1'b0, yOp};
    cy = u[BitEo] & ctl[1] & sum[WordW];
    bus = ctl[1] ? sum[WordW-1:0] : (xOp & yOp);
    bus = ctl[0] ? ~bus : bus;
    if (!u[BitEo]) begin
        case (srcSelT'(u[BitSrcHi:BitSrcLo]))
            SrcPc:   bus = s.pc;
            SrcIoh:  bus = {io, 8'h00};
            SrcIol:  bus = {8'h00, io};
            SrcMem:  bus = memWord;
            SrcD:    bus = s.d;
            default: bus = '0;
        endcase
    end
    jump = (u[BitJz] && bus == '0) || (u[BitJgt] && bus != '0 && !bus[WordW-1])
        || (u[BitJlt] && bus[WordW-1]) || (u[BitJc] && cy);
    r.next = s;
    case (dstSelT'(u[BitDstHi:BitDstLo]))
        DstA:    r.next.a = bus;
        DstI:    r.next.i = bus;
        DstX:    r.next.x = bus;
        DstY:    r.next.y = bus;
        DstD:    r.next.d = bus;
        default: ;
    endcase
    r.memWe = (u[BitDstHi:BitDstLo] == DstMem);
    r.memWdata = bus;
    // RT first, then a taken jump, then PP; all from the old registers.
    if (!u[BitEo] && u[BitRt]) begin
        r.next.pc = s.d;
    end else if (jump) begin
        r.next.pc = s.a;
    end else if (!u[BitEo] && u[BitPp]) begin
        r.next.pc = s.pc + 16'd1;
    end
    return r;
endfunction

`endif

// File: test/microCoreTb.sv
// Testbench for the microcoded core.
// Issues microinstruction sequences with random data, mirrors them in the
// reference model and compares registers, PC and memory writes every cycle.

`default_nettype none

module microCoreTb import microPkg::*; ();

    localparam int ResetCycles = 16;
    localparam int AluCount = 40;
    localparam int MemCount = 12;
    localparam int RandCount = 60;
    localparam int ChainCount = 80;
    localparam int InstrCount = 25 + 5 * AluCount + 3 * MemCount + 5 + RandCount + ChainCount;
    localparam int CycleLimit = 2 * InstrCount + ResetCycles + 64;

    `include "refModel.svh"

    logic       clk;
    logic       rstN;
    uinstrT     uinstr;
    logic       uValid;
    ioByteT     ioIn;
    wordT       memRdata;
    wordT       memAddr;
    wordT       memWdata;
    logic       memWe;
    wordT       pc;
    wordT       regI;
    wordT       regX;
    wordT       regY;
    wordT       regD;

    wordT       mem [0:65535];
    wordT       modelMem [0:65535];       // Expected contents.
    archStateT  model;
    stepResultT stepRes;
    ioByteT     ioStage;
    ioByteT     ioLate;
    logic       checkOn;
    int         checkCount;
    int         cycleCount;
    logic       pipeValid [0:1];
    uinstrT     pipeOp [0:1];
    ioByteT     pipeIo [0:1];
    srcSelT     srcList [0:4];
    dstSelT     dstList [0:4];
    uinstrT     op;

    microCore DUT (.*);

    assign memRdata = mem[memAddr];
    always @(posedge clk) begin
        if (memWe === 1'b1) begin
            mem[memAddr] <= memWdata;
        end
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles.", CycleLimit));
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic checkWord(input string what, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %0t %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %0t %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic uinstrT makeMove(input srcSelT src, input logic rt, input logic pp,
                                        input dstSelT dst, input logic [3:0] jumps);
        uinstrT u;
        u = '0;
        u[BitSrcHi:BitSrcLo] = src;
        u[BitRt] = rt;
        u[BitPp] = pp;
        u[BitDstHi:BitDstLo] = dst;
        u[BitJz:BitJc] = jumps;                    // JZ, JGT, JLT, JC.
        return u;
    endfunction

    function automatic uinstrT makeAlu(input aluCtrlT ctl, input dstSelT dst);
        uinstrT u;
        u = '0;
        u[BitEo] = 1'b1;
        u[BitAluHi:BitAluLo] = ctl;
        u[BitDstHi:BitDstLo] = dst;
        return u;
    endfunction

    // IO data reaches the pins two edges after its op, when that op executes.
    task automatic driveCycle(input logic valid, input uinstrT u, input ioByteT io);
        @(posedge clk);
        uValid <= valid;
        uinstr <= u;
        ioIn <= ioLate;
        ioLate = ioStage;
        ioStage = io;
    endtask

    task automatic issue(input uinstrT u, input ioByteT io, input logic allowGap);
        if (allowGap && ($urandom % 4 == 0)) begin
            driveCycle(1'b0, '0, '0);
        end
        driveCycle(1'b1, u, io);
    endtask

    // A strobe seen here is sampled at the next edge, executes in the cycle
    // after that and shows in the registers one cycle later.
    always @(negedge clk) begin
        if (checkOn) begin
            checkWord("pc", pc, model.pc);
            checkWord("regI", regI, model.i);
            checkWord("regX", regX, model.x);
            checkWord("regY", regY, model.y);
            checkWord("regD", regD, model.d);
            checkWord("memAddr", memAddr, model.a);
            if (pipeValid[1]) begin
                stepRes = stepModel(model, pipeOp[1], pipeIo[1], modelMem[model.a]);
                checkFlag("memWe", memWe, stepRes.memWe);
                if (stepRes.memWe) begin
                    checkWord("memWdata", memWdata, stepRes.memWdata);
                    modelMem[model.a] = stepRes.memWdata;
                end
                model = stepRes.next;
            end else begin
                checkFlag("memWe", memWe, 1'b0);
            end
            pipeValid[1] = pipeValid[0];
            pipeOp[1] = pipeOp[0];
            pipeIo[1] = pipeIo[0];
            pipeValid[0] = uValid;
            pipeOp[0] = uinstr;
            pipeIo[0] = ioStage;
        end
    end

    initial begin
        void'($urandom(32'h325a4355));
        clk = 1'b0;
        rstN = 1'b0;
        uinstr = '0;
        uValid = 1'b0;
        ioIn = '0;
        ioStage = '0;
        ioLate = '0;
        checkOn = 1'b0;
        checkCount = 0;
        cycleCount = 0;
        model = '0;
        pipeValid[0] = 1'b0;
        pipeValid[1] = 1'b0;
        srcList = '{SrcPc, SrcIoh, SrcIol, SrcMem, SrcD};
        dstList = '{DstA, DstI, DstX, DstY, DstD};
        for (int k = 0; k < 65536; k++) begin
            mem[k] = wordT'($urandom);
            modelMem[k] = mem[k];
        end
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        checkOn = 1'b1;
        repeat (4) driveCycle(1'b0, '0, '0);     // Idle state right after reset.
        foreach (srcList[s]) begin
            foreach (dstList[d]) begin
                op = makeMove(srcList[s], 1'b0, 1'($urandom), dstList[d], 4'b0000);
                issue(op, ioByteT'($urandom), 1'b1);
            end
        end
        // Random X and Y come from memory through A.
        for (int k = 0; k < AluCount; k++) begin
            issue(makeMove(SrcIol, 1'b0, 1'b0, DstA, 4'b0000), ioByteT'($urandom), 1'b1);
            issue(makeMove(SrcMem, 1'b0, 1'b0, DstX, 4'b0000), '0, 1'b1);
            issue(makeMove(SrcIoh, 1'b0, 1'b0, DstA, 4'b0000), ioByteT'($urandom), 1'b1);
            issue(makeMove(SrcMem, 1'b0, 1'b0, DstY, 4'b0000), '0, 1'b1);
            issue(makeAlu(aluCtrlT'($urandom), dstList[2 + $urandom % 3]), '0, 1'b1);
        end
        for (int k = 0; k < MemCount; k++) begin
            issue(makeMove(SrcIol, 1'b0, 1'b0, DstA, 4'b0000), ioByteT'($urandom), 1'b1);
            issue(makeAlu(aluCtrlT'($urandom), DstMem), '0, 1'b1);
            issue(makeMove(SrcMem, 1'b0, 1'b0, DstD, 4'b0000), '0, 1'b1);
        end
        issue(makeMove(SrcIol, 1'b0, 1'b0, DstD, 4'b0000), ioByteT'($urandom) | 8'h01, 1'b0);
        issue(makeMove(SrcIoh, 1'b0, 1'b0, DstA, 4'b0000), ioByteT'($urandom) | 8'h80, 1'b0);
        issue(makeMove(SrcIol, 1'b1, 1'b1, DstNone, 4'b1000), 8'h00, 1'b0);  // RT over JZ.
        issue(makeMove(SrcIol, 1'b0, 1'b1, DstNone, 4'b1000), 8'h00, 1'b0);  // JZ over PP.
        issue(makeMove(SrcIol, 1'b0, 1'b1, DstNone, 4'b1000), 8'h05, 1'b0);
        for (int k = 0; k < RandCount; k++) begin
            issue(uinstrT'($urandom), ioByteT'($urandom), 1'b1);
        end
        // Dependent ops with no gaps.
        for (int k = 0; k < ChainCount; k++) begin
            op = uinstrT'($urandom);
            op[BitDstHi:BitDstLo] = dstList[2 + $urandom % 3];
            issue(op, ioByteT'($urandom), 1'b0);
        end
        repeat (4) driveCycle(1'b0, '0, '0);
        if (checkCount > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            failRun("No checks were made during the run.");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+test
logic/microPkg.sv
logic/ctrlIf.sv
logic/microDecode.sv
logic/aluExecute.sv
logic/regWriteback.sv
logic/microCore.sv
test/microCoreTb.sv

// File: Bender.yml
package:
  name: micro_core

sources:
  - files:
      - logic/microPkg.sv
      - logic/ctrlIf.sv
      - logic/microDecode.sv
      - logic/aluExecute.sv
      - logic/regWriteback.sv
      - logic/microCore.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/microCoreTb.sv
